// File: run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rvseed_core_tb \
    && ./obj_dir/Vrvseed_core_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"

// File: sim.f
+incdir+verilog
verilog/rvs_pkg.sv
verilog/ctrl_if.sv
verilog/ctrl.sv
verilog/regfile.sv
verilog/exec_unit.sv
verilog/rvseed_core.sv
tb/rvseed_core_asserts.sv
tb/rvseed_core_tb.sv

// File: tb/core_vectors.hex
// per program: word count, program words, store count, store address/data pairs,
// final status (1 halted, 2 trapped), data count, initial data address/data pairs
// program 1: add sub addi addw sd lui addw auipc lw, x0 store, bne loop, jal jalr, ebreak
1f
10000513 00500093 FFD00113 002081B3
00353023 40110233 00453423 7FFFF2B7
0052833B 00653823 00553C23 00001397
02753023 18402403 02853423 00108033
02053823 00300593 02B53C23 00850513
FFF58593 FE059AE3 0080066F 00103023
02C53C23 07100713 000706E7 00103023
04D53023 00100073 00103023
// stores: add, sub, addw, lui, auipc, lw, x0, three loop passes, jal link, jalr link
c
100 0000000000000002
108 FFFFFFFFFFFFFFF8
110 FFFFFFFFFFFFE000
118 000000007FFFF000
120 000000000000102C
128 FFFFFFFF80000123
130 0000000000000000
138 0000000000000003
140 0000000000000002
148 0000000000000001
150 000000000000005C
158 000000000000006C
1
1
180 8000012300000042
// program 2: addi, sd, lw low word, sd, unsupported mul word, sd never reached
6
00700093 10103023 18002103 10203423
022081B3 00103023
2
100 0000000000000007
108 FFFFFFFFFFFFFFFE
2
1
180 00000000FFFFFFFE

// File: tb/rvseed_core_asserts.sv
`timescale 1ns/1ps

module rvseed_core_asserts (
    input logic           clk,
    input logic           rst_n,
    input rvs_pkg::xlen_t imem_addr,
    input logic           dmem_wen,
    input logic           halted,
    input logic           trapped
);

    no_store_when_stopped: assert property (
        @(posedge clk) disable iff (!rst_n) !(dmem_wen && (halted || trapped))
    ) else $error("store issued while the core is halted or trapped");

    status_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(halted && trapped)
    ) else $error("halted and trapped both high");

    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) imem_addr[1:0] == 2'b00
    ) else $error("fetch address not word aligned");

    // pc frozen once halted until the next reset
    halt_pc_frozen: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> $stable(imem_addr)
    ) else $error("fetch address moved while halted");

endmodule

bind rvseed_core rvseed_core_asserts rvseed_core_asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .dmem_wen  (dmem_wen),
    .halted    (halted),
    .trapped   (trapped)
);

// File: tb/rvseed_core_tb.sv
`timescale 1ns/1ps

module rvseed_core_tb;

    logic            clk;
    logic            rst_n;
    rvs_pkg::xlen_t  imem_addr;
    rvs_pkg::inst_t  imem_rdata;
    rvs_pkg::xlen_t  dmem_addr;
    rvs_pkg::xlen_t  dmem_wdata;
    rvs_pkg::wmask_t dmem_wmask;
    logic            dmem_wen;
    logic            dmem_ren;
    rvs_pkg::xlen_t  dmem_rdata;
    logic            halted;
    logic            trapped;

    logic [63:0]     vec [0:127];
    rvs_pkg::inst_t  imem [0:255];
    rvs_pkg::xlen_t  dmem [0:63];
    rvs_pkg::xlen_t  exp_addr [$];
    rvs_pkg::xlen_t  exp_data [$];
    int              vec_ptr;
    int              error_count;
    int              store_count;
    int              stores_checked;
    int              limit_ns;
    string           test_name;

    rvseed_core rvseed_core_i (.*);

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_ren ? dmem[dmem_addr[8:3]] : '0;   // 64 dwords, read on dmem_ren

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("error %s: expected %h, actual %h", name, expected, actual);
        error_count++;
    endtask

    task automatic finish_run();
        $display("closing: %0d errors, %0d stores checked", error_count, stores_checked);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // walks both program records and sums their word counts
    function automatic int total_words();
        int ptr;
        int total;
        ptr = 0;
        total = 0;
        for (int p = 0; p < 2; p++) begin
            total += int'(vec[ptr]);
            ptr += int'(vec[ptr]) + 1;
            ptr += 2 * int'(vec[ptr]) + 1;
            ptr += 1;                           // final status
            ptr += 2 * int'(vec[ptr]) + 1;
        end
        return total;
    endfunction

    always @(posedge clk) begin
        if (rst_n && dmem_wen) begin
            if (store_count >= exp_addr.size()) begin
                $display("unexpected store to %h in %s after its last expected store",
                         dmem_addr, test_name);
                error_count++;
            end else begin
                if (dmem_addr !== exp_addr[store_count])
                    report_mismatch($sformatf("%s_store%0d_addr", test_name, store_count),
                                    exp_addr[store_count], dmem_addr);
                if (dmem_wdata !== exp_data[store_count])
                    report_mismatch($sformatf("%s_store%0d_data", test_name, store_count),
                                    exp_data[store_count], dmem_wdata);
                if (dmem_wmask !== 8'hff)
                    report_mismatch($sformatf("%s_store%0d_mask", test_name, store_count),
                                    64'hff, 64'(dmem_wmask));
                stores_checked++;
            end
            store_count++;
            dmem[dmem_addr[8:3]] <= dmem_wdata;
        end
    end

    task automatic run_program(input string name);
        int          n_words;
        int          n_stores;
        int          n_data;
        logic [63:0] exp_status;
        logic [63:0] status;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        test_name = name;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= '0;
        end
        n_words = int'(vec[vec_ptr]);
        vec_ptr++;
        for (int i = 0; i < n_words; i++) begin
            imem[i] = vec[vec_ptr + i][31:0];
        end
        vec_ptr += n_words;
        n_stores = int'(vec[vec_ptr]);
        vec_ptr++;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < n_stores; i++) begin
            exp_addr.push_back(vec[vec_ptr]);
            exp_data.push_back(vec[vec_ptr + 1]);
            vec_ptr += 2;
        end
        exp_status = vec[vec_ptr];
        vec_ptr++;
        n_data = int'(vec[vec_ptr]);
        vec_ptr++;
        for (int i = 0; i < n_data; i++) begin
            dmem[vec[vec_ptr][8:3]] <= vec[vec_ptr + 1];
            vec_ptr += 2;
        end
        store_count = 0;
        repeat (3) begin
            @(negedge clk);
            if (imem_addr !== 64'h0) report_mismatch({name, "_reset_pc"}, 64'h0, imem_addr);
            if (dmem_wen !== 1'b0) report_mismatch({name, "_reset_wen"}, 64'h0, 64'(dmem_wen));
            if (halted !== 1'b0) report_mismatch({name, "_reset_halted"}, 64'h0, 64'(halted));
            if (trapped !== 1'b0) report_mismatch({name, "_reset_trapped"}, 64'h0, 64'(trapped));
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (imem_addr !== 64'h0) report_mismatch({name, "_start_pc"}, 64'h0, imem_addr);
        if (halted !== 1'b0 || trapped !== 1'b0)
            report_mismatch({name, "_start_status"}, 64'h0, {62'b0, trapped, halted});
        wait (halted || trapped);
        repeat (4) @(negedge clk);          // room for any stray store
        status = {62'b0, trapped, halted};
        if (status !== exp_status) report_mismatch({name, "_status"}, exp_status, status);
        if (store_count != n_stores)
            report_mismatch({name, "_store_count"}, 64'(n_stores), 64'(store_count));
    endtask

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout: core reached neither halted nor trapped in %0d ns", limit_ns);
        error_count++;
        finish_run();
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        error_count = 0;
        store_count = 0;
        stores_checked = 0;
        vec_ptr = 0;
        test_name = "init";
        for (int i = 0; i < 128; i++) begin
            vec[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= '0;
        end
        $readmemh("tb/core_vectors.hex", vec);
        limit_ns = total_words() * 16 * 8 + 2 * 4 * 8;    // 16 cycles per word plus resets
        run_program("prog1");
        run_program("prog2");
        finish_run();
    end

endmodule

// File: verilog/ctrl.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module ctrl (
    input  rvs_pkg::inst_t inst,
    ctrl_if.dec            c
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rvs_pkg::reg_addr_t rd;
    rvs_pkg::reg_addr_t rs1;
    rvs_pkg::reg_addr_t rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        c.reg_wen = 1'b0;
        c.waddr   = '0;
        c.raddr1  = '0;
        c.raddr2  = '0;
        c.imm_sel = rvs_pkg::IMM_I;
        c.alu_op  = rvs_pkg::ALU_ADD;
        c.alu_src = rvs_pkg::ALU_SRC_REG;
        c.branch  = 1'b0;
        c.jump    = 1'b0;
        c.jalr    = 1'b0;
        c.mem_ren = 1'b0;
        c.mem_wen = 1'b0;
        c.word_op = 1'b0;
        c.halt    = 1'b0;
        c.illegal = 1'b0;
        case (opcode)
            `OPC_OP: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.raddr1  = rs1;
                c.raddr2  = rs2;
                if (funct3 == `F3_ADD && funct7 == `F7_ADD) begin
                    c.alu_op = rvs_pkg::ALU_ADD;
                end else if (funct3 == `F3_ADD && funct7 == `F7_SUB) begin
                    c.alu_op = rvs_pkg::ALU_SUB;
                end else begin
                    c.illegal = 1'b1;
                end
            end
            `OPC_OP_IMM: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.raddr1  = rs1;
                c.alu_src = rvs_pkg::ALU_SRC_IMM;
                c.illegal = (funct3 != `F3_ADD);    // addi only
            end
            `OPC_OP_32: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.raddr1  = rs1;
                c.raddr2  = rs2;
                c.word_op = 1'b1;
                c.illegal = (funct3 != `F3_ADD) || (funct7 != `F7_ADD);
            end
            `OPC_LOAD: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.raddr1  = rs1;
                c.alu_src = rvs_pkg::ALU_SRC_IMM;
                c.mem_ren = 1'b1;
                c.illegal = (funct3 != `F3_LW);
            end
            `OPC_STORE: begin
                c.raddr1  = rs1;    // base
                c.raddr2  = rs2;    // store data
                c.imm_sel = rvs_pkg::IMM_S;
                c.alu_src = rvs_pkg::ALU_SRC_IMM;
                c.mem_wen = 1'b1;
                c.illegal = (funct3 != `F3_SD);
            end
            `OPC_BRANCH: begin
                c.raddr1  = rs1;
                c.raddr2  = rs2;
                c.imm_sel = rvs_pkg::IMM_B;
                c.alu_op  = rvs_pkg::ALU_SUB;   // zero when equal
                c.branch  = 1'b1;
                c.illegal = (funct3 != `F3_BNE);
            end
            `OPC_JAL: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.imm_sel = rvs_pkg::IMM_J;
                c.alu_src = rvs_pkg::ALU_SRC_FOUR_PC;   // link value
                c.jump    = 1'b1;
            end
            `OPC_JALR: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.raddr1  = rs1;
                c.alu_src = rvs_pkg::ALU_SRC_FOUR_PC;
                c.jump    = 1'b1;
                c.jalr    = 1'b1;
                c.illegal = (funct3 != `F3_JALR);
            end
            `OPC_LUI: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.imm_sel = rvs_pkg::IMM_U;
                c.alu_src = rvs_pkg::ALU_SRC_IMM;   // x0 + imm
            end
            `OPC_AUIPC: begin
                c.reg_wen = 1'b1;
                c.waddr   = rd;
                c.imm_sel = rvs_pkg::IMM_U;
                c.alu_src = rvs_pkg::ALU_SRC_IMM_PC;
            end
            `OPC_SYSTEM: begin
                c.halt    = (inst == `EBREAK_INST);
                c.illegal = (inst != `EBREAK_INST);
            end
            default: begin
                c.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: verilog/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;

    logic                  reg_wen;
    rvs_pkg::reg_addr_t    waddr;
    rvs_pkg::reg_addr_t    raddr1;
    rvs_pkg::reg_addr_t    raddr2;
    rvs_pkg::imm_sel_e     imm_sel;
    rvs_pkg::alu_op_e      alu_op;
    rvs_pkg::alu_src_e     alu_src;
    logic                  branch;
    logic                  jump;
    logic                  jalr;
    logic                  mem_ren;
    logic                  mem_wen;
    logic                  word_op;     // addw result sign extension
    logic                  halt;
    logic                  illegal;

    modport dec (
        output reg_wen, waddr, raddr1, raddr2, imm_sel, alu_op, alu_src,
               branch, jump, jalr, mem_ren, mem_wen, word_op, halt, illegal
    );

    modport exe (
        input  reg_wen, waddr, raddr1, raddr2, imm_sel, alu_op, alu_src,
               branch, jump, jalr, mem_ren, mem_wen, word_op, halt, illegal
    );

endinterface

// File: verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    ctrl_if.exe            c,
    input  rvs_pkg::inst_t inst,
    input  rvs_pkg::xlen_t pc,
    input  rvs_pkg::xlen_t rs1_data,
    input  rvs_pkg::xlen_t rs2_data,
    input  rvs_pkg::xlen_t mem_rdata,
    output rvs_pkg::xlen_t result,
    output rvs_pkg::xlen_t mem_addr,
    output rvs_pkg::xlen_t store_data,
    output rvs_pkg::xlen_t next_pc
);

    rvs_pkg::xlen_t imm;
    rvs_pkg::xlen_t op_a;
    rvs_pkg::xlen_t op_b;
    rvs_pkg::xlen_t alu_out;
    rvs_pkg::xlen_t alu_res;
    rvs_pkg::xlen_t target;
    rvs_pkg::xlen_t pc_plus4;
    logic [31:0]    load_word;
    logic           taken;

    always_comb begin
        case (c.imm_sel)
            rvs_pkg::IMM_S: imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            rvs_pkg::IMM_B: imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rvs_pkg::IMM_U: imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            rvs_pkg::IMM_J: imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:        imm = {{52{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        case (c.alu_src)
            rvs_pkg::ALU_SRC_IMM:     begin op_a = rs1_data; op_b = imm;      end
            rvs_pkg::ALU_SRC_IMM_PC:  begin op_a = pc;       op_b = imm;      end
            rvs_pkg::ALU_SRC_FOUR_PC: begin op_a = pc;       op_b = 64'd4;    end
            default:                  begin op_a = rs1_data; op_b = rs2_data; end
        endcase
    end

    assign alu_res  = (c.alu_op == rvs_pkg::ALU_SUB) ? op_a - op_b : op_a + op_b;
    assign alu_out  = c.word_op ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;
    assign pc_plus4 = pc + 64'd4;

    assign mem_addr   = alu_out;
    assign store_data = rs2_data;
    assign load_word  = alu_out[2] ? mem_rdata[63:32] : mem_rdata[31:0];   // word within dword

    always_comb begin
        if (c.mem_ren) begin
            result = {{32{load_word[31]}}, load_word};
        end else begin
            result = alu_out;                                   // link value for jumps
        end
    end

    assign taken   = c.branch && (alu_out != '0);     // bne
    assign target  = c.jalr ? ((rs1_data + imm) & ~64'd1) : pc + imm;
    assign next_pc = (taken || c.jump) ? target : pc_plus4;

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  rvs_pkg::reg_addr_t raddr1,
    input  rvs_pkg::reg_addr_t raddr2,
    output rvs_pkg::xlen_t     rdata1,
    output rvs_pkg::xlen_t     rdata2,
    input  logic               wen,
    input  rvs_pkg::reg_addr_t waddr,
    input  rvs_pkg::xlen_t     wdata
);

    rvs_pkg::xlen_t regs [1:(1 << `REG_ADDR_WIDTH) - 1];   // x0 not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << `REG_ADDR_WIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/rvs_macros.svh
`ifndef RVS_MACROS_SVH
`define RVS_MACROS_SVH

`define XLEN            64
`define REG_ADDR_WIDTH  5
`define RESET_PC        64'h0000_0000_0000_0000

`define OPC_OP          7'b0110011  // add, sub
`define OPC_OP_IMM      7'b0010011  // addi
`define OPC_OP_32       7'b0111011  // addw
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_SYSTEM      7'b1110011

`define F3_ADD          3'b000
`define F3_LW           3'b010
`define F3_SD           3'b011
`define F3_BNE          3'b001
`define F3_JALR         3'b000

`define F7_ADD          7'b0000000
`define F7_SUB          7'b0100000

`define EBREAK_INST     32'h0010_0073

`endif

// File: verilog/rvs_pkg.sv
`include "rvs_macros.svh"

package rvs_pkg;

    typedef logic [`XLEN-1:0]           xlen_t;
    typedef logic [31:0]                inst_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [7:0]                 wmask_t;    // byte strobe

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

    // operand pair fed to the alu
    typedef enum logic [1:0] {
        ALU_SRC_REG,        // rs1, rs2
        ALU_SRC_IMM,        // rs1, imm
        ALU_SRC_IMM_PC,     // pc, imm
        ALU_SRC_FOUR_PC     // pc, 4
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_HALTED,
        ST_TRAPPED
    } core_state_e;

endpackage

// File: verilog/rvseed_core.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module rvseed_core (
    input  logic            clk,
    input  logic            rst_n,
    output rvs_pkg::xlen_t  imem_addr,
    input  rvs_pkg::inst_t  imem_rdata,
    output rvs_pkg::xlen_t  dmem_addr,
    output rvs_pkg::xlen_t  dmem_wdata,
    output rvs_pkg::wmask_t dmem_wmask,
    output logic            dmem_wen,
    output logic            dmem_ren,
    input  rvs_pkg::xlen_t  dmem_rdata,
    output logic            halted,
    output logic            trapped
);

    rvs_pkg::xlen_t      pc;
    rvs_pkg::xlen_t      next_pc;
    rvs_pkg::xlen_t      rs1_data;
    rvs_pkg::xlen_t      rs2_data;
    rvs_pkg::xlen_t      result;
    rvs_pkg::core_state_e state;
    logic                retire;

    ctrl_if c_if ();

    ctrl u_ctrl (
        .inst (imem_rdata),
        .c    (c_if.dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (c_if.raddr1),
        .raddr2 (c_if.raddr2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .wen    (c_if.reg_wen && retire),
        .waddr  (c_if.waddr),
        .wdata  (result)
    );

    exec_unit u_exec (
        .c          (c_if.exe),
        .inst       (imem_rdata),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .mem_rdata  (dmem_rdata),
        .result     (result),
        .mem_addr   (dmem_addr),
        .store_data (dmem_wdata),
        .next_pc    (next_pc)
    );

    // ebreak and illegal words retire nothing
    assign retire = rst_n && (state == rvs_pkg::ST_RUN) && !c_if.halt && !c_if.illegal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rvs_pkg::ST_RUN;
        end else if (state == rvs_pkg::ST_RUN) begin
            if (c_if.halt) begin
                state <= rvs_pkg::ST_HALTED;
            end else if (c_if.illegal) begin
                state <= rvs_pkg::ST_TRAPPED;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (retire) begin
            pc <= next_pc;
        end
    end

    assign imem_addr  = pc;
    assign dmem_wen   = c_if.mem_wen && retire;
    assign dmem_ren   = c_if.mem_ren && retire;
    assign dmem_wmask = c_if.mem_wen ? '1 : '0;   // sd only
    assign halted     = (state == rvs_pkg::ST_HALTED);
    assign trapped    = (state == rvs_pkg::ST_TRAPPED);

endmodule
